//--- src/isa_pkg.sv
`default_nettype none

package isa_pkg;

	localparam int NUM_REGS = 32;

	typedef logic [31:0] xlen_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [3:0]  alu_fn_t;
	typedef logic [1:0]  b_sel_t;

	// ALU codes follow {funct7[5], funct3} of the OP group
	localparam alu_fn_t ALU_ADD  = 4'b0000;
	localparam alu_fn_t ALU_SUB  = 4'b1000;
	localparam alu_fn_t ALU_SLL  = 4'b0001;
	localparam alu_fn_t ALU_SLT  = 4'b0010;
	localparam alu_fn_t ALU_SLTU = 4'b0011;
	localparam alu_fn_t ALU_XOR  = 4'b0100;
	localparam alu_fn_t ALU_SRL  = 4'b0101;
	localparam alu_fn_t ALU_SRA  = 4'b1101;
	localparam alu_fn_t ALU_OR   = 4'b0110;
	localparam alu_fn_t ALU_AND  = 4'b0111;

	// Operand B sources
	localparam b_sel_t B_SEL_REG   = 2'b00;
	localparam b_sel_t B_SEL_IMM   = 2'b01;
	localparam b_sel_t B_SEL_SHAMT = 2'b10;

endpackage

`default_nettype wire

//--- src/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

	// Queue entries and credits handed out at reset
	localparam int QUEUE_DEPTH = 4;

	// Counts 0 .. QUEUE_DEPTH inclusive
	typedef logic [$clog2(QUEUE_DEPTH + 1)-1:0] credit_t;

	typedef logic [$clog2(QUEUE_DEPTH)-1:0] qptr_t;

	// Cycles squashed per flush including the flush cycle
	localparam int KILL_CYCLES = 2;

endpackage

`default_nettype wire

//--- src/issue_if.sv
`timescale 1ns/1ps
`default_nettype none

// Packet push from the issue stage and credit return from the queue
interface issue_if;

	logic              valid;
	isa_pkg::reg_addr_t rd;
	isa_pkg::alu_fn_t  alu_fn;
	isa_pkg::xlen_t    op_a;
	isa_pkg::xlen_t    op_b;
	logic              credit;

	modport producer (
		output valid, rd, alu_fn, op_a, op_b,
		input  credit
	);

	modport buffer (
		input  valid, rd, alu_fn, op_a, op_b,
		output credit
	);

endinterface

`default_nettype wire

//--- src/exec_if.sv
`timescale 1ns/1ps
`default_nettype none

// Queue head towards the ALU
interface exec_if;

	logic               valid;
	isa_pkg::reg_addr_t rd;
	isa_pkg::alu_fn_t   alu_fn;
	isa_pkg::xlen_t     op_a;
	isa_pkg::xlen_t     op_b;
	logic               pop;

	modport buffer (
		output valid, rd, alu_fn, op_a, op_b,
		input  pop
	);

	modport consumer (
		input  valid, rd, alu_fn, op_a, op_b,
		output pop
	);

endinterface

`default_nettype wire

//--- src/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input  wire logic               clk,
	input  wire logic               nrst,
	input  wire logic               wr_en,
	input  wire isa_pkg::reg_addr_t wr_addr,
	input  wire isa_pkg::xlen_t     wr_data,
	input  wire isa_pkg::reg_addr_t rs1,
	input  wire isa_pkg::reg_addr_t rs2,
	output isa_pkg::xlen_t          rdata1,
	output isa_pkg::xlen_t          rdata2
);

	isa_pkg::xlen_t regs [isa_pkg::NUM_REGS];

	// x0 reads as zero and a same-cycle write passes straight through
	function automatic isa_pkg::xlen_t read_port(input isa_pkg::reg_addr_t addr);
		if (addr == '0)
			return '0;
		else if (wr_en && (wr_addr == addr))
			return wr_data;
		else
			return regs[addr];
	endfunction

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < isa_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (wr_en && (wr_addr != '0))
		begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign rdata1 = read_port(rs1);
	assign rdata2 = read_port(rs2);

endmodule

`default_nettype wire

//--- src/scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module scoreboard (
	input  wire logic               clk,
	input  wire logic               nrst,
	input  wire isa_pkg::reg_addr_t rs1,
	input  wire isa_pkg::reg_addr_t rs2,
	input  wire isa_pkg::reg_addr_t rd,
	input  wire logic               uses_rs2,
	input  wire logic               issue,
	input  wire logic               flush,
	input  wire logic               wb_valid,
	input  wire isa_pkg::reg_addr_t wb_rd,
	output logic                    hazard,
	output logic                    kill
);

	logic [isa_pkg::NUM_REGS-1:0] busy;
	logic [isa_pkg::NUM_REGS-1:0] clr_mask;
	logic [isa_pkg::NUM_REGS-1:0] set_mask;
	logic [isa_pkg::NUM_REGS-1:0] busy_eff;
	logic [1:0]                   kill_cnt;

	// Register retiring this cycle is already free
	assign clr_mask = wb_valid ? (isa_pkg::NUM_REGS'(1) << wb_rd) : '0;
	assign set_mask = (issue && (rd != '0)) ? (isa_pkg::NUM_REGS'(1) << rd) : '0;
	assign busy_eff = busy & ~clr_mask;

	// RAW on either source, WAW on the destination
	assign hazard = busy_eff[rs1] | (uses_rs2 & busy_eff[rs2]) | busy_eff[rd];

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			busy <= '0;
		else
			busy <= busy_eff | set_mask;
	end

	// Flush cycle plus the remaining KILL_CYCLES-1 cycles
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			kill_cnt <= '0;
		else if (flush)
			kill_cnt <= 2'(pipe_pkg::KILL_CYCLES - 1);
		else if (kill_cnt != '0)
			kill_cnt <= kill_cnt - 2'd1;
	end

	assign kill = flush | (kill_cnt != '0);

endmodule

`default_nettype wire

//--- src/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
	input  wire logic               clk,
	input  wire logic               nrst,
	input  wire logic               dec_valid,
	input  wire isa_pkg::reg_addr_t dec_rs1,
	input  wire isa_pkg::reg_addr_t dec_rs2,
	input  wire isa_pkg::reg_addr_t dec_rd,
	input  wire isa_pkg::alu_fn_t   dec_alu_fn,
	input  wire isa_pkg::b_sel_t    dec_b_sel,
	input  wire isa_pkg::xlen_t     dec_imm,
	input  wire logic               flush,
	output logic                    dec_ready,
	input  wire logic               wb_valid,
	input  wire isa_pkg::reg_addr_t wb_rd,
	input  wire isa_pkg::xlen_t     wb_data,
	issue_if.producer               q
);

	isa_pkg::xlen_t    rdata1;
	isa_pkg::xlen_t    rdata2;
	isa_pkg::xlen_t    op_b_sel;
	logic              uses_rs2;
	logic              hazard;
	logic              kill;
	logic              accept;
	pipe_pkg::credit_t credits;

	regfile u_regfile (
		.clk     (clk),
		.nrst    (nrst),
		.wr_en   (wb_valid),
		.wr_addr (wb_rd),
		.wr_data (wb_data),
		.rs1     (dec_rs1),
		.rs2     (dec_rs2),
		.rdata1  (rdata1),
		.rdata2  (rdata2)
	);

	scoreboard u_scoreboard (
		.clk      (clk),
		.nrst     (nrst),
		.rs1      (dec_rs1),
		.rs2      (dec_rs2),
		.rd       (dec_rd),
		.uses_rs2 (uses_rs2),
		.issue    (accept),
		.flush    (flush),
		.wb_valid (wb_valid),
		.wb_rd    (wb_rd),
		.hazard   (hazard),
		.kill     (kill)
	);

	assign uses_rs2 = (dec_b_sel == isa_pkg::B_SEL_REG);

	always_comb
	begin
		unique case (dec_b_sel)
			isa_pkg::B_SEL_IMM:   op_b_sel = dec_imm;
			isa_pkg::B_SEL_SHAMT: op_b_sel = {27'b0, dec_imm[4:0]};
			default:              op_b_sel = rdata2;
		endcase
	end

	// Killed instructions are taken and dropped
	assign dec_ready = kill | (!hazard && (credits != '0));
	assign accept    = dec_valid & dec_ready & ~kill;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			q.valid <= 1'b0;
		else
			q.valid <= accept;
	end

	// Issue register payload
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			q.rd     <= dec_rd;
			q.alu_fn <= dec_alu_fn;
			q.op_a   <= rdata1;
			q.op_b   <= op_b_sel;
		end
	end

	// Credit spent on accept and returned on each pop
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			credits <= pipe_pkg::credit_t'(pipe_pkg::QUEUE_DEPTH);
		else if (accept && !q.credit)
			credits <= credits - 1'b1;
		else if (!accept && q.credit)
			credits <= credits + 1'b1;
	end

endmodule

`default_nettype wire

//--- src/issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

module issue_queue (
	input  wire logic clk,
	input  wire logic nrst,
	issue_if.buffer   in_q,
	exec_if.buffer    out_q
);

	isa_pkg::reg_addr_t rd_mem   [pipe_pkg::QUEUE_DEPTH];
	isa_pkg::alu_fn_t   fn_mem   [pipe_pkg::QUEUE_DEPTH];
	isa_pkg::xlen_t     op_a_mem [pipe_pkg::QUEUE_DEPTH];
	isa_pkg::xlen_t     op_b_mem [pipe_pkg::QUEUE_DEPTH];

	pipe_pkg::qptr_t    head;
	pipe_pkg::qptr_t    tail;
	pipe_pkg::credit_t  count;

	function automatic pipe_pkg::qptr_t next_ptr(input pipe_pkg::qptr_t ptr);
		if (ptr == pipe_pkg::qptr_t'(pipe_pkg::QUEUE_DEPTH - 1))
			return '0;
		else
			return ptr + 1'b1;
	endfunction

	// Push writes the slot at the tail
	always_ff @(posedge clk)
	begin
		if (in_q.valid)
		begin
			rd_mem[tail]   <= in_q.rd;
			fn_mem[tail]   <= in_q.alu_fn;
			op_a_mem[tail] <= in_q.op_a;
			op_b_mem[tail] <= in_q.op_b;
		end
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end
		else
		begin
			if (in_q.valid)
				tail <= next_ptr(tail);
			if (out_q.pop)
				head <= next_ptr(head);
			if (in_q.valid && !out_q.pop)
				count <= count + 1'b1;
			else if (!in_q.valid && out_q.pop)
				count <= count - 1'b1;
		end
	end

	assign out_q.valid  = (count != '0);
	assign out_q.rd     = rd_mem[head];
	assign out_q.alu_fn = fn_mem[head];
	assign out_q.op_a   = op_a_mem[head];
	assign out_q.op_b   = op_b_mem[head];

	// Freed slot goes back as a credit
	assign in_q.credit = out_q.pop;

endmodule

`default_nettype wire

//--- src/exec_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exec_alu (
	input  wire logic            clk,
	input  wire logic            nrst,
	input  wire logic            exec_ready,
	exec_if.consumer             q,
	output logic                 wb_valid,
	output isa_pkg::reg_addr_t   wb_rd,
	output isa_pkg::xlen_t       wb_data
);

	logic [4:0]     shamt;
	isa_pkg::xlen_t result;

	assign q.pop = q.valid & exec_ready;
	assign shamt = q.op_b[4:0];

	always_comb
	begin
		unique case (q.alu_fn)
			isa_pkg::ALU_ADD:  result = q.op_a + q.op_b;
			isa_pkg::ALU_SUB:  result = q.op_a - q.op_b;
			isa_pkg::ALU_AND:  result = q.op_a & q.op_b;
			isa_pkg::ALU_OR:   result = q.op_a | q.op_b;
			isa_pkg::ALU_XOR:  result = q.op_a ^ q.op_b;
			isa_pkg::ALU_SLL:  result = q.op_a << shamt;
			isa_pkg::ALU_SRL:  result = q.op_a >> shamt;
			isa_pkg::ALU_SRA:  result = isa_pkg::xlen_t'($signed(q.op_a) >>> shamt);
			isa_pkg::ALU_SLT:  result = {31'b0, $signed(q.op_a) < $signed(q.op_b)};
			isa_pkg::ALU_SLTU: result = {31'b0, q.op_a < q.op_b};
			default:           result = '0;
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			wb_valid <= 1'b0;
		else
			wb_valid <= q.pop;
	end

	// Result and destination captured on each pop
	always_ff @(posedge clk)
	begin
		if (q.pop)
		begin
			wb_rd   <= q.rd;
			wb_data <= result;
		end
	end

endmodule

`default_nettype wire

//--- src/issue_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module issue_subsystem (
	input  wire logic               clk,
	input  wire logic               nrst,
	input  wire logic               dec_valid,
	input  wire isa_pkg::reg_addr_t dec_rs1,
	input  wire isa_pkg::reg_addr_t dec_rs2,
	input  wire isa_pkg::reg_addr_t dec_rd,
	input  wire isa_pkg::alu_fn_t   dec_alu_fn,
	input  wire isa_pkg::b_sel_t    dec_b_sel,
	input  wire isa_pkg::xlen_t     dec_imm,
	input  wire logic               flush,
	input  wire logic               exec_ready,
	output logic                    dec_ready,
	output logic                    wb_valid,
	output isa_pkg::reg_addr_t      wb_rd,
	output isa_pkg::xlen_t          wb_data
);

	issue_if issue_bus ();
	exec_if  exec_bus ();

	issue_stage u_issue_stage (
		.clk        (clk),
		.nrst       (nrst),
		.dec_valid  (dec_valid),
		.dec_rs1    (dec_rs1),
		.dec_rs2    (dec_rs2),
		.dec_rd     (dec_rd),
		.dec_alu_fn (dec_alu_fn),
		.dec_b_sel  (dec_b_sel),
		.dec_imm    (dec_imm),
		.flush      (flush),
		.dec_ready  (dec_ready),
		.wb_valid   (wb_valid),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data),
		.q          (issue_bus.producer)
	);

	issue_queue u_issue_queue (
		.clk   (clk),
		.nrst  (nrst),
		.in_q  (issue_bus.buffer),
		.out_q (exec_bus.buffer)
	);

	// Writeback also feeds the regfile and scoreboard in the issue stage
	exec_alu u_exec_alu (
		.clk        (clk),
		.nrst       (nrst),
		.exec_ready (exec_ready),
		.q          (exec_bus.consumer),
		.wb_valid   (wb_valid),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data)
	);

endmodule

`default_nettype wire

//--- tb/tb_issue_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_issue_subsystem;

	localparam logic [31:0] SEED = 32'h3074_4541;
	localparam int DEP_COUNT = 60;
	localparam int BP_OFFER = pipe_pkg::QUEUE_DEPTH + 2;
	localparam int TOTAL_INSTR = (isa_pkg::NUM_REGS - 1) + 1 + 30 + DEP_COUNT + BP_OFFER + 5 + 3;
	localparam int WATCHDOG_CYCLES = TOTAL_INSTR * 8 + 200;
	localparam int EXP_SLOTS = 64;

	logic               clk;
	logic               nrst;
	logic               dec_valid;
	isa_pkg::reg_addr_t dec_rs1;
	isa_pkg::reg_addr_t dec_rs2;
	isa_pkg::reg_addr_t dec_rd;
	isa_pkg::alu_fn_t   dec_alu_fn;
	isa_pkg::b_sel_t    dec_b_sel;
	isa_pkg::xlen_t     dec_imm;
	logic               flush;
	logic               exec_ready;
	logic               dec_ready;
	logic               wb_valid;
	isa_pkg::reg_addr_t wb_rd;
	isa_pkg::xlen_t     wb_data;

	// Reference register file and expected writeback FIFO
	isa_pkg::xlen_t     model_regs [isa_pkg::NUM_REGS];
	isa_pkg::reg_addr_t exp_rd_q [EXP_SLOTS];
	isa_pkg::xlen_t     exp_data_q [EXP_SLOTS];
	int                 exp_wr;
	int                 exp_rdp;
	int                 kill_left;
	logic               in_kill;
	int                 errors;

	issue_subsystem uut (
		.clk        (clk),
		.nrst       (nrst),
		.dec_valid  (dec_valid),
		.dec_rs1    (dec_rs1),
		.dec_rs2    (dec_rs2),
		.dec_rd     (dec_rd),
		.dec_alu_fn (dec_alu_fn),
		.dec_b_sel  (dec_b_sel),
		.dec_imm    (dec_imm),
		.flush      (flush),
		.exec_ready (exec_ready),
		.dec_ready  (dec_ready),
		.wb_valid   (wb_valid),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data)
	);

	always #10 clk = ~clk;

	function automatic isa_pkg::xlen_t alu_result(input isa_pkg::alu_fn_t fn,
			input isa_pkg::xlen_t a, input isa_pkg::xlen_t b);
		int sh;
		sh = b[4:0];
		case (fn)
			isa_pkg::ALU_ADD:  return a + b;
			isa_pkg::ALU_SUB:  return a - b;
			isa_pkg::ALU_AND:  return a & b;
			isa_pkg::ALU_OR:   return a | b;
			isa_pkg::ALU_XOR:  return a ^ b;
			isa_pkg::ALU_SLL:  return a << sh;
			isa_pkg::ALU_SRL:  return a >> sh;
			isa_pkg::ALU_SRA:  return $unsigned($signed(a) >>> sh);
			isa_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			isa_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
			default:           return '0;
		endcase
	endfunction

	function automatic isa_pkg::alu_fn_t fn_by_index(input int idx);
		case (idx)
			0:       return isa_pkg::ALU_ADD;
			1:       return isa_pkg::ALU_SUB;
			2:       return isa_pkg::ALU_AND;
			3:       return isa_pkg::ALU_OR;
			4:       return isa_pkg::ALU_XOR;
			5:       return isa_pkg::ALU_SLL;
			6:       return isa_pkg::ALU_SRL;
			7:       return isa_pkg::ALU_SRA;
			8:       return isa_pkg::ALU_SLT;
			default: return isa_pkg::ALU_SLTU;
		endcase
	endfunction

	function automatic isa_pkg::b_sel_t bsel_by_index(input int idx);
		case (idx)
			0:       return isa_pkg::B_SEL_REG;
			1:       return isa_pkg::B_SEL_IMM;
			default: return isa_pkg::B_SEL_SHAMT;
		endcase
	endfunction

	function automatic isa_pkg::reg_addr_t rand_reg();
		return isa_pkg::reg_addr_t'($urandom_range(31, 1));
	endfunction

	// Model step for one accepted instruction
	task automatic record_accept();
		isa_pkg::xlen_t a;
		isa_pkg::xlen_t b;
		isa_pkg::xlen_t res;
		a = model_regs[dec_rs1];
		if (dec_b_sel == isa_pkg::B_SEL_IMM)
			b = dec_imm;
		else if (dec_b_sel == isa_pkg::B_SEL_SHAMT)
			b = {27'b0, dec_imm[4:0]};
		else
			b = model_regs[dec_rs2];
		res = alu_result(dec_alu_fn, a, b);
		exp_rd_q[exp_wr % EXP_SLOTS] = dec_rd;
		exp_data_q[exp_wr % EXP_SLOTS] = res;
		exp_wr++;
		if (dec_rd != '0)
			model_regs[dec_rd] = res;
	endtask

	// Inputs are stable at the falling edge, so the handshake is decided here
	always @(negedge clk)
	begin
		if (!nrst)
		begin
			kill_left = 0;
		end
		else
		begin
			in_kill = flush || (kill_left != 0);
			if (in_kill)
			begin
				assert (dec_ready)
				else
				begin
					errors++;
					$display("ERROR %0t: dec_ready low inside the flush window", $time);
				end
			end
			if (dec_valid && dec_ready && !in_kill)
				record_accept();
			if (flush)
				kill_left = pipe_pkg::KILL_CYCLES - 1;
			else if (kill_left != 0)
				kill_left--;
		end
	end

	always @(posedge clk)
	begin
		if (nrst && wb_valid && (exp_rdp != exp_wr))
			exp_rdp <= exp_rdp + 1;
	end

	assert property (@(posedge clk) disable iff (!nrst) wb_valid |-> (exp_rdp != exp_wr))
	else
	begin
		errors++;
		$display("ERROR %0t: writeback with no instruction outstanding", $time);
	end

	assert property (@(posedge clk) disable iff (!nrst)
		(wb_valid && (exp_rdp != exp_wr)) |->
		(wb_rd == exp_rd_q[exp_rdp % EXP_SLOTS] && wb_data == exp_data_q[exp_rdp % EXP_SLOTS]))
	else
	begin
		errors++;
		$display("ERROR %0t: writeback rd %0d data %h, expected rd %0d data %h", $time,
			$sampled(wb_rd), $sampled(wb_data),
			exp_rd_q[$sampled(exp_rdp) % EXP_SLOTS], exp_data_q[$sampled(exp_rdp) % EXP_SLOTS]);
	end

	task automatic set_fields(input isa_pkg::reg_addr_t rs1, input isa_pkg::reg_addr_t rs2,
			input isa_pkg::reg_addr_t rd, input isa_pkg::alu_fn_t fn,
			input isa_pkg::b_sel_t bsel, input isa_pkg::xlen_t imm);
		dec_rs1 = rs1;
		dec_rs2 = rs2;
		dec_rd = rd;
		dec_alu_fn = fn;
		dec_b_sel = bsel;
		dec_imm = imm;
	endtask

	// Offer one instruction and hold it until the handshake completes
	task automatic send_instr(input isa_pkg::reg_addr_t rs1, input isa_pkg::reg_addr_t rs2,
			input isa_pkg::reg_addr_t rd, input isa_pkg::alu_fn_t fn,
			input isa_pkg::b_sel_t bsel, input isa_pkg::xlen_t imm);
		set_fields(rs1, rs2, rd, fn, bsel, imm);
		dec_valid = 1'b1;
		@(negedge clk);
		while (!dec_ready)
			@(negedge clk);
		@(posedge clk);
		#2;
		dec_valid = 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_rdp != exp_wr)
			@(posedge clk);
		@(posedge clk);
		#2;
	endtask

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Checks failed");
		$finish;
	end

	initial
	begin
		int i;
		int k;
		int cycles;
		int stalls;
		int bp_accepted;
		isa_pkg::reg_addr_t recent [4];
		isa_pkg::reg_addr_t pick_rd;

		void'($urandom(SEED));
		clk = 1'b0;
		nrst = 1'b0;
		dec_valid = 1'b0;
		set_fields('0, '0, '0, isa_pkg::ALU_ADD, isa_pkg::B_SEL_REG, '0);
		flush = 1'b0;
		exec_ready = 1'b1;
		exp_wr = 0;
		exp_rdp = 0;
		kill_left = 0;
		in_kill = 1'b0;
		errors = 0;
		for (i = 0; i < isa_pkg::NUM_REGS; i++)
			model_regs[i] = '0;

		repeat (3) @(posedge clk);
		#2;
		nrst = 1'b1;
		@(negedge clk);
		assert (!wb_valid && dec_ready)
		else
		begin
			errors++;
			$display("ERROR %0t: after reset wb_valid %b dec_ready %b", $time, wb_valid, dec_ready);
		end
		@(posedge clk);
		#2;

		// Random contents for every register
		for (i = 1; i < isa_pkg::NUM_REGS; i++)
			send_instr('0, '0, isa_pkg::reg_addr_t'(i), isa_pkg::ALU_ADD, isa_pkg::B_SEL_IMM,
				$urandom);
		wait_drain();

		// Latency from the accept edge to writeback on an idle pipeline
		send_instr(rand_reg(), rand_reg(), rand_reg(), isa_pkg::ALU_ADD, isa_pkg::B_SEL_REG, '0);
		cycles = 0;
		do
		begin
			@(negedge clk);
			cycles++;
		end
		while (!wb_valid && cycles < 10);
		assert (cycles == 3)
		else
		begin
			errors++;
			$display("ERROR %0t: idle latency %0d cycles, expected 3", $time, cycles);
		end
		@(posedge clk);
		#2;
		wait_drain();

		for (i = 0; i < 10; i++)
		begin
			for (k = 0; k < 3; k++)
				send_instr(rand_reg(), rand_reg(), rand_reg(), fn_by_index(i), bsel_by_index(k),
					$urandom);
		end
		wait_drain();

		// Sources taken from the most recent destinations
		for (k = 0; k < 4; k++)
			recent[k] = isa_pkg::reg_addr_t'(k + 1);
		for (i = 0; i < DEP_COUNT; i++)
		begin
			pick_rd = rand_reg();
			send_instr(recent[$urandom_range(3)], recent[$urandom_range(3)], pick_rd,
				fn_by_index($urandom_range(9)), bsel_by_index($urandom_range(2)), $urandom);
			for (k = 3; k > 0; k--)
				recent[k] = recent[k - 1];
			recent[0] = pick_rd;
		end
		wait_drain();

		// Back-pressure with independent instructions
		exec_ready = 1'b0;
		bp_accepted = 0;
		stalls = 0;
		k = 0;
		set_fields(5'd16, '0, 5'd1, isa_pkg::ALU_ADD, isa_pkg::B_SEL_IMM, $urandom);
		dec_valid = 1'b1;
		while (stalls < 4 && k < BP_OFFER)
		begin
			@(negedge clk);
			if (dec_ready)
			begin
				bp_accepted++;
				k++;
				stalls = 0;
			end
			else
			begin
				stalls++;
			end
			@(posedge clk);
			#2;
			set_fields(isa_pkg::reg_addr_t'(16 + k), '0, isa_pkg::reg_addr_t'(1 + k),
				isa_pkg::ALU_XOR, isa_pkg::B_SEL_IMM, $urandom);
		end
		dec_valid = 1'b0;
		assert (bp_accepted == pipe_pkg::QUEUE_DEPTH)
		else
		begin
			errors++;
			$display("ERROR %0t: %0d accepted under back-pressure, expected %0d", $time,
				bp_accepted, pipe_pkg::QUEUE_DEPTH);
		end
		exec_ready = 1'b1;
		wait_drain();

		// Flush over a pending RAW hazard on x8 that would otherwise hold dec_ready low
		send_instr(rand_reg(), '0, 5'd8, isa_pkg::ALU_ADD, isa_pkg::B_SEL_IMM, $urandom);
		set_fields(5'd8, '0, 5'd9, isa_pkg::ALU_ADD, isa_pkg::B_SEL_IMM, $urandom);
		dec_valid = 1'b1;
		flush = 1'b1;
		@(posedge clk);
		#2;
		flush = 1'b0;
		set_fields(5'd8, '0, 5'd10, isa_pkg::ALU_XOR, isa_pkg::B_SEL_IMM, $urandom);
		@(posedge clk);
		#2;
		dec_valid = 1'b0;
		// Reads of the dropped targets
		send_instr(5'd9, 5'd10, 5'd11, isa_pkg::ALU_ADD, isa_pkg::B_SEL_REG, '0);
		send_instr(5'd10, '0, 5'd12, isa_pkg::ALU_OR, isa_pkg::B_SEL_IMM, '0);
		wait_drain();

		// Write to x0 and read it back
		send_instr(rand_reg(), '0, '0, isa_pkg::ALU_ADD, isa_pkg::B_SEL_IMM, $urandom | 32'd1);
		send_instr('0, '0, 5'd13, isa_pkg::ALU_OR, isa_pkg::B_SEL_REG, '0);
		send_instr('0, '0, 5'd14, isa_pkg::ALU_ADD, isa_pkg::B_SEL_IMM, $urandom);
		wait_drain();

		$display("Summary: %0d errors, %0d of %0d writebacks checked", errors, exp_rdp, exp_wr);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
src/isa_pkg.sv
src/pipe_pkg.sv
src/issue_if.sv
src/exec_if.sv
src/regfile.sv
src/scoreboard.sv
src/issue_stage.sv
src/issue_queue.sv
src/exec_alu.sv
src/issue_subsystem.sv
tb/tb_issue_subsystem.sv

//--- Bender.yml
package:
  name: issue_subsystem

sources:
  - src/isa_pkg.sv
  - src/pipe_pkg.sv
  - src/issue_if.sv
  - src/exec_if.sv
  - src/regfile.sv
  - src/scoreboard.sv
  - src/issue_stage.sv
  - src/issue_queue.sv
  - src/exec_alu.sv
  - src/issue_subsystem.sv
  - target: test
    files:
      - tb/tb_issue_subsystem.sv
